//--- filelist.f
+incdir+.
ntm_scalar_pkg.sv
ntm_request_queue.sv
ntm_scalar_multiplier.sv
ntm_scalar_inverter.sv
ntm_scalar_dispatcher.sv
ntm_scalar_unit.sv
ntm_scalar_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the scalar unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ntm_scalar_unit_tb -f filelist.f

./obj_dir/Vntm_scalar_unit_tb > sim.log
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  echo "run_sim: testbench reported success"
else
  echo "run_sim: testbench reported failure"
  exit 1
fi

//--- ntm_scalar_model.svh
/*
 * Reference model of the scalar modular-arithmetic unit
 * Modular add, subtract, multiply and inverse, plus the stimulus LCG
 */

`ifndef NTM_SCALAR_MODEL_SVH
`define NTM_SCALAR_MODEL_SVH

// 32-bit LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [63:0] mod_add(input logic [63:0] a, input logic [63:0] b,
                                        input logic [63:0] m);
  return (a + b) % m;
endfunction

function automatic logic [63:0] mod_sub(input logic [63:0] a, input logic [63:0] b,
                                        input logic [63:0] m);
  return (a + m - b) % m;
endfunction

// Full 64-bit product, then one reduction
function automatic logic [63:0] mod_mul(input logic [63:0] a, input logic [63:0] b,
                                        input logic [63:0] m);
  return (a * b) % m;
endfunction

// Signed extended Euclid on (m, a)
function automatic logic [63:0] mod_inverse(input logic [63:0] a, input logic [63:0] m);
  longint t;
  longint new_t;
  longint r;
  longint new_r;
  longint q;
  longint tmp;
  t     = 0;
  new_t = 1;
  r     = longint'(m);
  new_r = longint'(a);
  while (new_r != 0) begin
    q     = r / new_r;
    tmp   = t - q * new_t;
    t     = new_t;
    new_t = tmp;
    tmp   = r - q * new_r;
    r     = new_r;
    new_r = tmp;
  end
  if (t < 0) t = t + longint'(m);
  return t;
endfunction

function automatic logic [63:0] model_result(input ntm_scalar_pkg::opcode_t op,
                                             input logic [63:0] a, input logic [63:0] b,
                                             input logic [63:0] m);
  case (op)
    ntm_scalar_pkg::OP_ADD: return mod_add(a, b, m);
    ntm_scalar_pkg::OP_SUB: return mod_sub(a, b, m);
    ntm_scalar_pkg::OP_MUL: return mod_mul(a, b, m);
    ntm_scalar_pkg::OP_INV: return mod_inverse(a, m);
    ntm_scalar_pkg::OP_DIV: return mod_mul(a, mod_inverse(b, m), m);
    default:                return 64'd0;
  endcase
endfunction

`endif

//--- ntm_scalar_unit_tb.sv
/*
 * Testbench of the scalar modular-arithmetic unit
 * Random credit-gated requests, random credit return, checked against a model
 */

`timescale 1ns/1ps

`include "ntm_defines.svh"

module ntm_scalar_unit_tb;

  `include "ntm_scalar_model.svh"

  localparam int DW            = `NTM_DATA_SIZE;
  localparam int NUM_REQ       = 300;
  // Consumer stalls once this many requests have gone out
  localparam int STARVE_AT     = 120;
  localparam int STARVE_CYCLES = 50;
  // Two cycles per inverter step plus the multiply
  localparam int DIV_CYCLES    = 9 * DW + 8;
  localparam longint TIMEOUT_NS =
    (longint'(NUM_REQ) * DIV_CYCLES + STARVE_CYCLES + 100) * 100;

  localparam logic [31:0] PRIMES [8] = '{
    32'd4294967291, 32'd4294967279, 32'd4294967231, 32'd4294967197,
    32'd3221225473, 32'd2147483647, 32'd2013265921, 32'd65521
  };

  logic                    CLK;
  logic                    RST;
  logic                    REQ_VALID;
  ntm_scalar_pkg::opcode_t REQ_OPCODE;
  logic [DW-1:0]           REQ_A;
  logic [DW-1:0]           REQ_B;
  logic [DW-1:0]           REQ_MODULO;
  logic                    REQ_CREDIT;
  logic                    RSP_VALID;
  logic [DW-1:0]           RSP_DATA;
  logic                    RSP_CREDIT;

  logic [31:0] lcg_state;
  int          req_credits;
  int          rsp_credits;
  int          sent;
  int          received;
  int          cycle;
  int          starve_until;
  int          stall_cycles;
  int          checks;
  int          value_errors;
  int          protocol_errors;

  // Expected responses in request order
  logic [DW-1:0]           exp_data_q [$];
  ntm_scalar_pkg::opcode_t exp_op_q   [$];
  logic [63:0]             exp_a_q    [$];
  logic [63:0]             exp_m_q    [$];
  // Cycle at which each held response credit goes back
  int                      credit_due_q [$];

  ntm_scalar_unit ntm_scalar_unit_i (
    .CLK, .RST, .REQ_VALID, .REQ_OPCODE, .REQ_A, .REQ_B, .REQ_MODULO,
    .REQ_CREDIT, .RSP_VALID, .RSP_DATA, .RSP_CREDIT
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Stimulus helpers

  // Upper halves of two LCG steps
  function automatic logic [31:0] draw_random();
    logic [15:0] hi;
    lcg_state = lcg_next(lcg_state);
    hi        = lcg_state[31:16];
    lcg_state = lcg_next(lcg_state);
    return {hi, lcg_state[31:16]};
  endfunction

  task automatic send_request();
    ntm_scalar_pkg::opcode_t op;
    logic [63:0]             m;
    logic [63:0]             a;
    logic [63:0]             b;
    op = ntm_scalar_pkg::opcode_t'(3'(draw_random() % 32'd5));
    m  = 64'(PRIMES[3'(draw_random() % 32'd8)]);
    // Operands in 1 .. m-1
    a  = 64'd1 + (64'(draw_random()) % (m - 64'd1));
    b  = 64'd1 + (64'(draw_random()) % (m - 64'd1));
    REQ_VALID  = 1'b1;
    REQ_OPCODE = op;
    REQ_A      = a[DW-1:0];
    REQ_B      = b[DW-1:0];
    REQ_MODULO = m[DW-1:0];
    exp_data_q.push_back(DW'(model_result(op, a, b, m)));
    exp_op_q.push_back(op);
    exp_a_q.push_back(a);
    exp_m_q.push_back(m);
    req_credits--;
    sent++;
  endtask

  //////////////////////////////////////////////////
  // Response checking and credit return

  task automatic check_response();
    logic [DW-1:0]           expected;
    ntm_scalar_pkg::opcode_t op;
    logic [63:0]             a;
    logic [63:0]             m;
    assert (rsp_credits > 0) else begin
      protocol_errors++;
      $display("Response issued at %0t while the unit held no response credit", $time);
    end
    rsp_credits--;
    credit_due_q.push_back(cycle + int'(draw_random() % 32'd6));
    if (exp_data_q.size() == 0) begin
      protocol_errors++;
      $display("Response at %0t with no request outstanding", $time);
    end else begin
      expected = exp_data_q.pop_front();
      op       = exp_op_q.pop_front();
      a        = exp_a_q.pop_front();
      m        = exp_m_q.pop_front();
      checks++;
      received++;
      assert (RSP_DATA === expected) else begin
        value_errors++;
        $display("FAIL %0t: %s expected %h, got %h", $time, op.name(), expected, RSP_DATA);
      end
      // Inverse property on top of the model match
      if (op == ntm_scalar_pkg::OP_INV) begin
        assert (mod_mul(a, 64'(RSP_DATA), m) == 64'd1) else begin
          value_errors++;
          $display("FAIL %0t: a*inv mod m is not 1 for a=%h, inv=%h", $time, a, RSP_DATA);
        end
      end
    end
  endtask

  task automatic return_credit();
    RSP_CREDIT = 1'b0;
    if (cycle >= starve_until && credit_due_q.size() > 0) begin
      if (credit_due_q[0] <= cycle) begin
        void'(credit_due_q.pop_front());
        RSP_CREDIT = 1'b1;
        rsp_credits++;
      end
    end
  endtask

  // Runs 1 ns after each rising edge on settled outputs
  task automatic run_cycle();
    cycle++;
    if (REQ_CREDIT) begin
      req_credits++;
      assert (req_credits <= `NTM_QUEUE_DEPTH) else begin
        protocol_errors++;
        $display("More request credits returned than requests sent at %0t", $time);
      end
    end
    if (RSP_VALID) check_response();
    // Credits exhausted inside the starvation window
    if (rsp_credits == 0 && cycle < starve_until) stall_cycles++;
    // Start of the starvation window
    if (sent == STARVE_AT && starve_until == 0) starve_until = cycle + STARVE_CYCLES;
    return_credit();
    REQ_VALID = 1'b0;
    if (sent < NUM_REQ && req_credits > 0 && (draw_random() % 32'd4) != 0) send_request();
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    RST             = 1'b1;
    REQ_VALID       = 1'b0;
    REQ_OPCODE      = ntm_scalar_pkg::OP_ADD;
    REQ_A           = '0;
    REQ_B           = '0;
    REQ_MODULO      = '0;
    RSP_CREDIT      = 1'b0;
    lcg_state       = 32'd82799;
    req_credits     = `NTM_QUEUE_DEPTH;
    rsp_credits     = `NTM_RSP_CREDITS;
    sent            = 0;
    received        = 0;
    cycle           = 0;
    starve_until    = 0;
    stall_cycles    = 0;
    checks          = 0;
    value_errors    = 0;
    protocol_errors = 0;
    repeat (4) @(posedge CLK);
    #1 RST = 1'b0;
    while (received < NUM_REQ) begin
      @(posedge CLK);
      #1;
      run_cycle();
    end
    // Idle tail where no response may appear
    repeat (20) begin
      @(posedge CLK);
      #1;
      run_cycle();
    end
    assert (stall_cycles > 0) else begin
      protocol_errors++;
      $display("Response credits never ran out during the starvation window");
    end
    $display("Checks %0d, value errors %0d, protocol errors %0d",
             checks, value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0t with %0d of %0d responses received",
             $time, received, NUM_REQ);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- ntm_scalar_unit.sv
/*
 * Scalar modular-arithmetic unit, top level
 * Request queue, dispatcher, inverter and multiplier on credit-based ports
 */

`timescale 1ns/1ps

`include "ntm_defines.svh"

module ntm_scalar_unit (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      REQ_VALID,
  input  ntm_scalar_pkg::opcode_t   REQ_OPCODE,
  input  logic [`NTM_DATA_SIZE-1:0] REQ_A,
  input  logic [`NTM_DATA_SIZE-1:0] REQ_B,
  input  logic [`NTM_DATA_SIZE-1:0] REQ_MODULO,
  output logic                      REQ_CREDIT,
  output logic                      RSP_VALID,
  output logic [`NTM_DATA_SIZE-1:0] RSP_DATA,
  input  logic                      RSP_CREDIT
);

  // Queue head
  logic                      head_valid;
  ntm_scalar_pkg::opcode_t   head_opcode;
  logic [`NTM_DATA_SIZE-1:0] head_a;
  logic [`NTM_DATA_SIZE-1:0] head_b;
  logic [`NTM_DATA_SIZE-1:0] head_modulo;
  logic                      pop;

  // Engine handshakes
  logic                      inv_start;
  logic                      inv_ready;
  logic [`NTM_DATA_SIZE-1:0] inv_data;
  logic [`NTM_DATA_SIZE-1:0] inv_result;
  logic                      mul_start;
  logic                      mul_ready;
  logic [`NTM_DATA_SIZE-1:0] mul_a;
  logic [`NTM_DATA_SIZE-1:0] mul_b;
  logic [`NTM_DATA_SIZE-1:0] mul_result;
  logic [`NTM_DATA_SIZE-1:0] op_modulo;

  ntm_request_queue request_queue_i (
    .CLK, .RST, .REQ_VALID, .REQ_OPCODE, .REQ_A, .REQ_B, .REQ_MODULO,
    .pop, .head_valid, .head_opcode, .head_a, .head_b, .head_modulo, .REQ_CREDIT
  );

  ntm_scalar_dispatcher dispatcher_i (
    .CLK, .RST, .head_valid, .head_opcode, .head_a, .head_b, .head_modulo, .pop,
    .inv_start, .inv_data, .inv_ready, .inv_result,
    .mul_start, .mul_a, .mul_b, .mul_ready, .mul_result,
    .op_modulo, .RSP_CREDIT, .RSP_VALID, .RSP_DATA
  );

  // Both engines share the latched modulus
  ntm_scalar_inverter #(.DATA_SIZE(`NTM_DATA_SIZE)) inverter_i (
    .CLK, .RST, .START(inv_start), .READY(inv_ready),
    .MODULO_IN(op_modulo), .DATA_IN(inv_data), .DATA_OUT(inv_result)
  );

  ntm_scalar_multiplier #(.DATA_SIZE(`NTM_DATA_SIZE)) multiplier_i (
    .CLK, .RST, .START(mul_start), .READY(mul_ready),
    .DATA_A(mul_a), .DATA_B(mul_b), .MODULO_IN(op_modulo), .DATA_OUT(mul_result)
  );

endmodule

//--- ntm_scalar_dispatcher.sv
/*
 * Request dispatcher
 * Pops the queue head, runs add/sub locally, sequences the inverter and
 * multiplier, and issues responses against the response credit counter
 */

`timescale 1ns/1ps

`include "ntm_defines.svh"

module ntm_scalar_dispatcher (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      head_valid,
  input  ntm_scalar_pkg::opcode_t   head_opcode,
  input  logic [`NTM_DATA_SIZE-1:0] head_a,
  input  logic [`NTM_DATA_SIZE-1:0] head_b,
  input  logic [`NTM_DATA_SIZE-1:0] head_modulo,
  output logic                      pop,
  output logic                      inv_start,
  output logic [`NTM_DATA_SIZE-1:0] inv_data,
  input  logic                      inv_ready,
  input  logic [`NTM_DATA_SIZE-1:0] inv_result,
  output logic                      mul_start,
  output logic [`NTM_DATA_SIZE-1:0] mul_a,
  output logic [`NTM_DATA_SIZE-1:0] mul_b,
  input  logic                      mul_ready,
  input  logic [`NTM_DATA_SIZE-1:0] mul_result,
  output logic [`NTM_DATA_SIZE-1:0] op_modulo,
  input  logic                      RSP_CREDIT,
  output logic                      RSP_VALID,
  output logic [`NTM_DATA_SIZE-1:0] RSP_DATA
);

  localparam int DW = `NTM_DATA_SIZE;
  localparam int CW = $clog2(`NTM_RSP_CREDITS + 1);

  ntm_scalar_pkg::dispatch_state_t state;
  ntm_scalar_pkg::opcode_t         op_code;

  logic [DW-1:0] op_a;
  logic [DW-1:0] op_b;
  logic [DW-1:0] result_q;
  logic [DW-1:0] arith_result;
  logic [DW:0]   sum_ext;
  logic [DW:0]   diff_ext;
  logic [CW-1:0] credit_cnt;
  logic          send;

  //////////////////////////////////////////////////
  // Add and subtract, one correction by m

  assign sum_ext  = {1'b0, op_a} + {1'b0, op_b};
  assign diff_ext = {1'b0, op_a} - {1'b0, op_b};

  always_comb begin
    case (op_code)
      ntm_scalar_pkg::OP_ADD:
        arith_result = (sum_ext >= {1'b0, op_modulo}) ? DW'(sum_ext - {1'b0, op_modulo})
                                                      : sum_ext[DW-1:0];
      // Borrow out means a < b, wrap back by m
      ntm_scalar_pkg::OP_SUB:
        arith_result = diff_ext[DW] ? diff_ext[DW-1:0] + op_modulo : diff_ext[DW-1:0];
      default:
        arith_result = '0;
    endcase
  end

  // Take the head only when idle
  assign pop = (state == ntm_scalar_pkg::DSP_IDLE) && head_valid;

  // Response goes out the cycle a credit is available
  assign send      = (state == ntm_scalar_pkg::DSP_WAIT_CREDIT) && (credit_cnt != '0);
  assign RSP_VALID = send;
  assign RSP_DATA  = result_q;

  //////////////////////////////////////////////////
  // Control FSM and credits

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ntm_scalar_pkg::DSP_IDLE;
      op_code    <= ntm_scalar_pkg::OP_ADD;
      inv_start  <= 1'b0;
      mul_start  <= 1'b0;
      credit_cnt <= CW'(`NTM_RSP_CREDITS);
    end else begin
      inv_start <= 1'b0;
      mul_start <= 1'b0;
      case ({RSP_CREDIT, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      case (state)
        ntm_scalar_pkg::DSP_IDLE: begin
          if (head_valid) begin
            op_code <= head_opcode;
            case (head_opcode)
              ntm_scalar_pkg::OP_MUL: begin
                mul_start <= 1'b1;
                state     <= ntm_scalar_pkg::DSP_WAIT_MUL;
              end
              ntm_scalar_pkg::OP_INV, ntm_scalar_pkg::OP_DIV: begin
                inv_start <= 1'b1;
                state     <= ntm_scalar_pkg::DSP_WAIT_INV;
              end
              default: state <= ntm_scalar_pkg::DSP_ARITH;
            endcase
          end
        end
        ntm_scalar_pkg::DSP_ARITH: state <= ntm_scalar_pkg::DSP_WAIT_CREDIT;
        ntm_scalar_pkg::DSP_WAIT_INV: begin
          if (inv_ready) begin
            // DIV chains into a multiply by a
            if (op_code == ntm_scalar_pkg::OP_DIV) begin
              mul_start <= 1'b1;
              state     <= ntm_scalar_pkg::DSP_WAIT_MUL;
            end else begin
              state <= ntm_scalar_pkg::DSP_WAIT_CREDIT;
            end
          end
        end
        ntm_scalar_pkg::DSP_WAIT_MUL: begin
          if (mul_ready) state <= ntm_scalar_pkg::DSP_WAIT_CREDIT;
        end
        default: begin
          if (send) state <= ntm_scalar_pkg::DSP_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Operand and result registers

  always_ff @(posedge CLK) begin
    if (pop) begin
      op_a      <= head_a;
      op_b      <= head_b;
      op_modulo <= head_modulo;
      mul_a     <= head_a;
      mul_b     <= head_b;
      // INV inverts a, DIV inverts b
      inv_data  <= (head_opcode == ntm_scalar_pkg::OP_INV) ? head_a : head_b;
    end
    if (state == ntm_scalar_pkg::DSP_ARITH) begin
      result_q <= arith_result;
    end
    if (state == ntm_scalar_pkg::DSP_WAIT_INV && inv_ready) begin
      if (op_code == ntm_scalar_pkg::OP_DIV) begin
        mul_a <= op_a;
        mul_b <= inv_result;
      end else begin
        result_q <= inv_result;
      end
    end
    if (state == ntm_scalar_pkg::DSP_WAIT_MUL && mul_ready) begin
      result_q <= mul_result;
    end
  end

endmodule

//--- ntm_scalar_inverter.sv
/*
 * Binary extended-Euclid modular inverter
 * DATA_OUT * DATA_IN = 1 mod MODULO_IN, odd modulus and coprime operand
 */

`timescale 1ns/1ps

`include "ntm_defines.svh"

module ntm_scalar_inverter #(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  ntm_scalar_pkg::inverter_state_t state;

  // Invariants x*a = u and y*a = v mod m
  logic [DATA_SIZE:0] u_q;
  logic [DATA_SIZE:0] v_q;
  logic [DATA_SIZE:0] x_q;
  logic [DATA_SIZE:0] y_q;

  logic [DATA_SIZE:0] modulo_ext;
  logic [DATA_SIZE:0] x_half;
  logic [DATA_SIZE:0] y_half;
  logic               u_one;
  logic               v_one;
  logic               x_lt_m;
  logic               y_lt_m;

  assign modulo_ext = {1'b0, MODULO_IN};
  assign u_one      = (u_q == (DATA_SIZE+1)'(1));
  assign v_one      = (v_q == (DATA_SIZE+1)'(1));
  assign x_lt_m     = (x_q < modulo_ext);
  assign y_lt_m     = (y_q < modulo_ext);

  // Coefficient halving, odd values made even by adding m first
  assign x_half = (x_q[0] ? x_q + modulo_ext : x_q) >> 1;
  assign y_half = (y_q[0] ? y_q + modulo_ext : y_q) >> 1;

  //////////////////////////////////////////////////
  // Step sequencing

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_scalar_pkg::STARTER;
      READY <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (state)
        ntm_scalar_pkg::STARTER: begin
          if (START) state <= ntm_scalar_pkg::ENDER;
        end
        ntm_scalar_pkg::ENDER: begin
          // Done once the coefficient is reduced below m
          if (u_one) begin
            if (x_lt_m) begin
              READY <= 1'b1;
              state <= ntm_scalar_pkg::STARTER;
            end
          end else if (v_one) begin
            if (y_lt_m) begin
              READY <= 1'b1;
              state <= ntm_scalar_pkg::STARTER;
            end
          end else if (!u_q[0]) begin
            state <= ntm_scalar_pkg::CHECK_U;
          end else if (!v_q[0]) begin
            state <= ntm_scalar_pkg::CHECK_V;
          end else begin
            state <= ntm_scalar_pkg::CHECK_D;
          end
        end
        default: state <= ntm_scalar_pkg::ENDER;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath

  always_ff @(posedge CLK) begin
    case (state)
      ntm_scalar_pkg::STARTER: begin
        if (START) begin
          u_q <= {1'b0, DATA_IN};
          v_q <= modulo_ext;
          x_q <= (DATA_SIZE+1)'(1);
          y_q <= '0;
        end
      end
      ntm_scalar_pkg::ENDER: begin
        if (u_one) begin
          if (x_lt_m) DATA_OUT <= x_q[DATA_SIZE-1:0];
          else        x_q      <= x_q - modulo_ext;
        end else if (v_one) begin
          if (y_lt_m) DATA_OUT <= y_q[DATA_SIZE-1:0];
          else        y_q      <= y_q - modulo_ext;
        end
      end
      ntm_scalar_pkg::CHECK_U: begin
        u_q <= u_q >> 1;
        x_q <= x_half;
      end
      ntm_scalar_pkg::CHECK_V: begin
        v_q <= v_q >> 1;
        y_q <= y_half;
      end
      default: begin
        // Both odd, subtract smaller from larger
        if (u_q < v_q) begin
          v_q <= v_q - u_q;
          y_q <= (y_q > x_q) ? y_q - x_q : y_q - x_q + modulo_ext;
        end else begin
          u_q <= u_q - v_q;
          x_q <= (x_q > y_q) ? x_q - y_q : x_q - y_q + modulo_ext;
        end
      end
    endcase
  end

endmodule

//--- ntm_scalar_multiplier.sv
/*
 * Interleaved modular multiplier
 * MSB-first shift-and-add, one bit of DATA_B per cycle after a load cycle
 */

`timescale 1ns/1ps

`include "ntm_defines.svh"

module ntm_scalar_multiplier #(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] DATA_A,
  input  logic [DATA_SIZE-1:0] DATA_B,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  localparam int CNT_W = $clog2(DATA_SIZE + 1);

  ntm_scalar_pkg::multiplier_state_t state;

  logic [CNT_W-1:0]     bit_cnt;
  logic [DATA_SIZE-1:0] a_q;
  logic [DATA_SIZE-1:0] b_q;
  logic [DATA_SIZE-1:0] acc_q;

  // Two guard bits, 2*acc + a stays below 3*m
  logic [DATA_SIZE+1:0] modulo_ext;
  logic [DATA_SIZE+1:0] acc_sum;
  logic [DATA_SIZE+1:0] acc_sub1;
  logic [DATA_SIZE+1:0] acc_sub2;

  //////////////////////////////////////////////////
  // One interleaved step

  assign modulo_ext = {2'b00, MODULO_IN};
  assign acc_sum    = {1'b0, acc_q, 1'b0} + (b_q[DATA_SIZE-1] ? {2'b00, a_q} : '0);
  assign acc_sub1   = (acc_sum >= modulo_ext) ? acc_sum - modulo_ext : acc_sum;
  assign acc_sub2   = (acc_sub1 >= modulo_ext) ? acc_sub1 - modulo_ext : acc_sub1;

  //////////////////////////////////////////////////
  // Control

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= ntm_scalar_pkg::MUL_IDLE;
      READY   <= 1'b0;
      bit_cnt <= '0;
    end else begin
      READY <= 1'b0;
      case (state)
        ntm_scalar_pkg::MUL_IDLE: begin
          if (START) begin
            bit_cnt <= CNT_W'(DATA_SIZE);
            state   <= ntm_scalar_pkg::MUL_RUN;
          end
        end
        default: begin
          bit_cnt <= bit_cnt - 1'b1;
          // Last bit consumed
          if (bit_cnt == CNT_W'(1)) begin
            READY <= 1'b1;
            state <= ntm_scalar_pkg::MUL_IDLE;
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath

  always_ff @(posedge CLK) begin
    if (state == ntm_scalar_pkg::MUL_IDLE) begin
      if (START) begin
        a_q   <= DATA_A;
        b_q   <= DATA_B;
        acc_q <= '0;
      end
    end else begin
      acc_q <= acc_sub2[DATA_SIZE-1:0];
      b_q   <= {b_q[DATA_SIZE-2:0], 1'b0};
      if (bit_cnt == CNT_W'(1)) begin
        DATA_OUT <= acc_sub2[DATA_SIZE-1:0];
      end
    end
  end

endmodule

//--- ntm_request_queue.sv
/*
 * Request FIFO in front of the dispatcher
 * Circular buffer sized by the credit count, one credit returned per pop
 */

`timescale 1ns/1ps

`include "ntm_defines.svh"

module ntm_request_queue (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          REQ_VALID,
  input  ntm_scalar_pkg::opcode_t       REQ_OPCODE,
  input  logic [`NTM_DATA_SIZE-1:0]     REQ_A,
  input  logic [`NTM_DATA_SIZE-1:0]     REQ_B,
  input  logic [`NTM_DATA_SIZE-1:0]     REQ_MODULO,
  input  logic                          pop,
  output logic                          head_valid,
  output ntm_scalar_pkg::opcode_t       head_opcode,
  output logic [`NTM_DATA_SIZE-1:0]     head_a,
  output logic [`NTM_DATA_SIZE-1:0]     head_b,
  output logic [`NTM_DATA_SIZE-1:0]     head_modulo,
  output logic                          REQ_CREDIT
);

  localparam int DEPTH = `NTM_QUEUE_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  // Entry storage
  ntm_scalar_pkg::opcode_t       opcode_mem [DEPTH];
  logic [`NTM_DATA_SIZE-1:0]     a_mem      [DEPTH];
  logic [`NTM_DATA_SIZE-1:0]     b_mem      [DEPTH];
  logic [`NTM_DATA_SIZE-1:0]     modulo_mem [DEPTH];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;

  //////////////////////////////////////////////////
  // Pointers and occupancy

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      REQ_CREDIT <= 1'b0;
    end else begin
      // Producer only sends while holding a credit, so no overflow check
      if (REQ_VALID) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({REQ_VALID, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back per entry freed
      REQ_CREDIT <= pop;
    end
  end

  //////////////////////////////////////////////////
  // Storage write, head read

  always_ff @(posedge CLK) begin
    if (REQ_VALID) begin
      opcode_mem[wr_ptr] <= REQ_OPCODE;
      a_mem[wr_ptr]      <= REQ_A;
      b_mem[wr_ptr]      <= REQ_B;
      modulo_mem[wr_ptr] <= REQ_MODULO;
    end
  end

  assign head_valid  = (count != '0);
  assign head_opcode = opcode_mem[rd_ptr];
  assign head_a      = a_mem[rd_ptr];
  assign head_b      = b_mem[rd_ptr];
  assign head_modulo = modulo_mem[rd_ptr];

endmodule

//--- ntm_scalar_pkg.sv
/*
 * Scalar modular-arithmetic unit
 * Opcode encoding and FSM state types shared by the engines and dispatcher
 */

package ntm_scalar_pkg;

  // Request opcodes
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_MUL = 3'd2,
    OP_INV = 3'd3,
    OP_DIV = 3'd4
  } opcode_t;

  // Binary extended-Euclid inverter steps
  typedef enum logic [2:0] {STARTER, ENDER, CHECK_U, CHECK_V, CHECK_D} inverter_state_t;

  // Shift-and-add multiplier
  typedef enum logic {MUL_IDLE, MUL_RUN} multiplier_state_t;

  // Request dispatcher
  typedef enum logic [2:0] {
    DSP_IDLE, DSP_ARITH, DSP_WAIT_INV, DSP_WAIT_MUL, DSP_WAIT_CREDIT
  } dispatch_state_t;

endpackage

//--- ntm_defines.svh
/*
 * Scalar modular-arithmetic unit
 * Global sizing macros for the datapath, request queue and response credits
 */

`ifndef NTM_DEFINES_SVH
`define NTM_DEFINES_SVH

// Operand and modulus width in bits
`define NTM_DATA_SIZE 32

// Request queue entries, also the producer's initial request credits
`define NTM_QUEUE_DEPTH 4

// Response credits held by the unit after reset
`define NTM_RSP_CREDITS 2

`endif
